/* Bender.yml */
package:
  name: spinn_aer_if

sources:
  - verilog/spinn_aer_pkg.sv
  - verilog/pkt_router.sv
  - verilog/spinn_aer_ctrl.sv
  - verilog/aer_out_mapper.sv
  - verilog/aer_in_mapper.sv
  - verilog/spinn_aer_if_top.sv
  - target: test
    files:
      - bench/spinn_aer_if_chk.sv
      - bench/tb_spinn_aer_if.sv

/* bench/spinn_aer_if_chk.sv */
// handshake checker for the SpiNNaker / AER bridge packet core
// packet output hold until ready, AER output request release and
// AER input acknowledge idle level

`timescale 1ns/1ps
`default_nettype none

module spinn_aer_if_chk (
  input wire                                i_clk,
  input wire                                i_rst_n,
  input wire [spinn_aer_pkg::PKT_BITS-1:0]  i_pkt_data,
  input wire                                i_pkt_vld,
  input wire                                i_pkt_rdy,
  input wire                                i_oreq,
  input wire                                i_oack,
  input wire                                i_ireq,
  input wire                                i_iack
);

  logic   ack_m1;
  logic   ack_m2;
  // failed property count
  integer fail_cnt = 0;

  // own copy of the acknowledge synchroniser idling high
  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      ack_m1 <= 1'b1;
      ack_m2 <= 1'b1;
    end else begin
      ack_m1 <= i_oack;
      ack_m2 <= ack_m1;
    end
  end

  // --------------------------------------------------------------------------
  // properties
  // --------------------------------------------------------------------------
  // offered packet held until taken
  ipkt_hold: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    (i_pkt_vld && !i_pkt_rdy) |=> (i_pkt_vld && $stable(i_pkt_data)))
    else begin
      $error("packet output dropped or changed before ready");
      fail_cnt = fail_cnt + 1;
    end

  // request release only after the synchronised ack went low
  oreq_release: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    $rose(i_oreq) |-> !$past(ack_m2))
    else begin
      $error("AER output request released while ack still high");
      fail_cnt = fail_cnt + 1;
    end

  // ack back high once the source has been idle
  iack_idle: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    (i_ireq && $past(i_ireq) && $past(i_ireq, 2)) |=> i_iack)
    else begin
      $error("AER input ack low with request idle");
      fail_cnt = fail_cnt + 1;
    end

endmodule

bind spinn_aer_if_top spinn_aer_if_chk u_chk (
  .i_clk      (i_clk),
  .i_rst_n    (i_rst_n),
  .i_pkt_data (o_ipkt_data),
  .i_pkt_vld  (o_ipkt_vld),
  .i_pkt_rdy  (i_ipkt_rdy),
  .i_oreq     (o_oaer_req),
  .i_oack     (i_oaer_ack),
  .i_ireq     (i_iaer_req),
  .i_iack     (o_iaer_ack)
);

`default_nettype wire

/* bench/tb_spinn_aer_if.sv */
// testbench for the SpiNNaker / AER bridge packet core
// drives AER input events and SpiNNaker packets, models the AER output
// device and compares mapped packets and output events with a reference

`timescale 1ns/1ps
`default_nettype none

module tb_spinn_aer_if;

  // 55 input events at up to ~20 cycles each, 20 output events
  // at up to ~25 cycles each, plus control traffic and margin
  localparam int MAX_CYCLES = 4000;

  logic                                 i_clk;
  logic                                 i_rst_n;
  logic [spinn_aer_pkg::PKT_BITS-1:0]   i_spkt_data;
  logic                                 i_spkt_vld;
  wire                                  o_spkt_rdy;
  wire  [spinn_aer_pkg::PKT_BITS-1:0]   o_ipkt_data;
  wire                                  o_ipkt_vld;
  logic                                 i_ipkt_rdy;
  logic [spinn_aer_pkg::AER_BITS-1:0]   i_iaer_data;
  logic                                 i_iaer_req;
  wire                                  o_iaer_ack;
  wire  [spinn_aer_pkg::AER_BITS-1:0]   o_oaer_data;
  wire                                  o_oaer_req;
  logic                                 i_oaer_ack;
  wire                                  o_dump_mode;

  // expected controller state
  spinn_aer_pkg::mode_t                 exp_mode;
  logic [spinn_aer_pkg::VCRD_BITS-1:0]  exp_vcoord;
  logic                                 exp_go;

  // expectations in order of arrival
  logic [spinn_aer_pkg::PKT_BITS-1:0]   exp_ipkt[$];
  logic [spinn_aer_pkg::AER_BITS-1:0]   exp_oaer[$];

  integer                               seed;
  integer                               dev_seed;
  integer                               rdy_seed;
  integer                               cycles = 0;
  integer                               n;
  logic                                 rdy_random;
  logic                                 prev_req;
  logic [31:0]                          rnd_key;

  spinn_aer_if_top DUT (
    .i_clk       (i_clk),
    .i_rst_n     (i_rst_n),
    .i_spkt_data (i_spkt_data),
    .i_spkt_vld  (i_spkt_vld),
    .o_spkt_rdy  (o_spkt_rdy),
    .o_ipkt_data (o_ipkt_data),
    .o_ipkt_vld  (o_ipkt_vld),
    .i_ipkt_rdy  (i_ipkt_rdy),
    .i_iaer_data (i_iaer_data),
    .i_iaer_req  (i_iaer_req),
    .o_iaer_ack  (o_iaer_ack),
    .o_oaer_data (o_oaer_data),
    .o_oaer_req  (o_oaer_req),
    .i_oaer_ack  (i_oaer_ack),
    .o_dump_mode (o_dump_mode)
  );

  // 100 ns clock
  initial begin
    i_clk = 1'b0;
    forever #50 i_clk = ~i_clk;
  end

  // --------------------------------------------------------------------------
  // helpers
  // --------------------------------------------------------------------------
  // step to 1 ns after the next rising edge
  task automatic tick;
    @(posedge i_clk);
    #1;
  endtask

  task automatic stop_with_failure(input string why);
    $display("%s", why);
    $display("Finished with errors");
    $fatal(1);
  endtask

  task automatic check_value(input string name,
                             input logic [spinn_aer_pkg::PKT_BITS-1:0] got,
                             input logic [spinn_aer_pkg::PKT_BITS-1:0] exp);
    if (got !== exp) begin
      $display("[ERROR] %0t ns %s got %h expected %h", $time, name, got, exp);
      stop_with_failure("value mismatch");
    end
  endtask

  // expected packet for one AER address
  function automatic logic [spinn_aer_pkg::PKT_BITS-1:0] map_event(
      input logic [15:0] addr, input spinn_aer_pkg::mode_t mode,
      input logic [15:0] vcrd);
    logic [15:0] lo;
    logic [31:0] key;
    integer      ones;
    integer      b;
    if (mode == spinn_aer_pkg::MODE_RETINA_64) begin
      // zero pad, y, x, polarity
      lo = {3'b000, addr[14:9], addr[6:1], addr[7]};
    end else begin
      lo = addr;
    end
    key  = {vcrd, lo};
    ones = 0;
    for (b = 0; b < 32; b++) begin
      ones = ones + key[b];
    end
    // zero header with bit 0 making the packet odd
    map_event = {key, 7'b0000000, (ones % 2 == 0)};
  endfunction

  // one four-phase event from the AER source
  task automatic send_event(input logic [15:0] addr);
    if (exp_go) begin
      exp_ipkt.push_back(map_event(addr, exp_mode, exp_vcoord));
    end
    i_iaer_data = addr;
    tick;
    i_iaer_req = 1'b0;
    while (o_iaer_ack) tick;
    i_iaer_req = 1'b1;
    while (!o_iaer_ack) tick;
  endtask

  // valid/ready transfer into the router
  task automatic send_spkt(input logic [spinn_aer_pkg::PKT_BITS-1:0] data);
    i_spkt_data = data;
    i_spkt_vld  = 1'b1;
    while (!o_spkt_rdy) tick;
    tick;
    i_spkt_vld  = 1'b0;
  endtask

  task automatic drive_ctrl(input logic [3:0] cmd, input logic [15:0] value);
    send_spkt({12'hFFF, cmd, value, 8'h00});
    case (cmd)
      spinn_aer_pkg::CMD_SET_VCRD: exp_vcoord = value;
      spinn_aer_pkg::CMD_SET_MODE: exp_mode = spinn_aer_pkg::mode_t'(value[1:0]);
      spinn_aer_pkg::CMD_GO:       exp_go = 1'b1;
      spinn_aer_pkg::CMD_STOP:     exp_go = 1'b0;
      default: ;
    endcase
    // router slot then controller register
    repeat (2) tick;
    check_value("o_dump_mode", o_dump_mode, !exp_go);
  endtask

  // --------------------------------------------------------------------------
  // AER output device with random ack delays
  // --------------------------------------------------------------------------
  initial begin : aer_device
    integer delay;
    forever begin
      tick;
      if (!o_oaer_req) begin
        delay = $random(dev_seed) & 7;
        repeat (delay) tick;
        i_oaer_ack = 1'b0;
        while (!o_oaer_req) tick;
        delay = $random(dev_seed) & 7;
        repeat (delay) tick;
        i_oaer_ack = 1'b1;
      end
    end
  end

  // packet sink holding ready low for random stretches when enabled
  initial begin : ipkt_sink
    integer stretch;
    forever begin
      tick;
      if (rdy_random) begin
        stretch    = $random(rdy_seed) & 7;
        i_ipkt_rdy = 1'b0;
        repeat (stretch) tick;
        i_ipkt_rdy = 1'b1;
      end
    end
  end

  // --------------------------------------------------------------------------
  // comparison and run limit
  // --------------------------------------------------------------------------
  always @(posedge i_clk) begin
    if (i_rst_n) begin
      if (o_ipkt_vld && exp_ipkt.size() == 0) begin
        stop_with_failure("packet offered on o_ipkt while none was expected");
      end else if (o_ipkt_vld && i_ipkt_rdy) begin
        check_value("o_ipkt_data", o_ipkt_data, exp_ipkt.pop_front());
      end
      // falling request marks a new output event
      if (prev_req && !o_oaer_req) begin
        if (exp_oaer.size() == 0) begin
          stop_with_failure("AER output event with no packet sent for it");
        end else begin
          check_value("o_oaer_data", o_oaer_data, exp_oaer.pop_front());
        end
      end
      prev_req = o_oaer_req;
    end else begin
      prev_req = 1'b1;
    end
  end

  // bound handshake checker
  always @(posedge i_clk) begin
    if (DUT.u_chk.fail_cnt != 0) begin
      stop_with_failure("a handshake assertion in the bound checker failed");
    end
  end

  always @(posedge i_clk) begin
    cycles = cycles + 1;
    if (cycles >= MAX_CYCLES) begin
      stop_with_failure("run hit the cycle limit, a handshake never completed");
    end
  end

  // --------------------------------------------------------------------------
  // stimulus
  // --------------------------------------------------------------------------
  initial begin
    seed        = 33;
    dev_seed    = seed + 1;
    rdy_seed    = seed + 2;
    rdy_random  = 1'b0;
    prev_req    = 1'b1;
    exp_mode    = spinn_aer_pkg::MODE_DIRECT;
    exp_vcoord  = '0;
    exp_go      = 1'b0;
    i_rst_n     = 1'b0;
    i_spkt_data = '0;
    i_spkt_vld  = 1'b0;
    i_ipkt_rdy  = 1'b1;
    i_iaer_data = '0;
    i_iaer_req  = 1'b1;
    i_oaer_ack  = 1'b1;
    repeat (3) tick;
    i_rst_n = 1'b1;
    tick;

    // dump mode out of reset
    check_value("o_dump_mode", o_dump_mode, 1'b1);
    for (n = 0; n < 5; n++) send_event($random(seed));

    // direct mapping
    drive_ctrl(spinn_aer_pkg::CMD_SET_VCRD, 16'h5A3C);
    drive_ctrl(spinn_aer_pkg::CMD_SET_MODE, 16'(spinn_aer_pkg::MODE_DIRECT));
    drive_ctrl(spinn_aer_pkg::CMD_GO, 16'h0000);
    for (n = 0; n < 20; n++) send_event($random(seed));

    // retina mapping under back-pressure
    drive_ctrl(spinn_aer_pkg::CMD_SET_MODE, 16'(spinn_aer_pkg::MODE_RETINA_64));
    rdy_random = 1'b1;
    for (n = 0; n < 20; n++) send_event($random(seed));
    rdy_random = 1'b0;

    // packets to AER output with keys kept off the control signature
    for (n = 0; n < 20; n++) begin
      rnd_key = $random(seed);
      if (rnd_key[31:20] == 12'hFFF) rnd_key[31] = 1'b0;
      exp_oaer.push_back(rnd_key[15:0]);
      send_spkt({rnd_key, 8'h00});
    end
    while (exp_oaer.size() != 0) tick;

    // stop, unknown code, then go again with unchanged settings
    drive_ctrl(spinn_aer_pkg::CMD_STOP, 16'h0000);
    for (n = 0; n < 5; n++) send_event($random(seed));
    drive_ctrl(4'h9, 16'h0000);
    drive_ctrl(spinn_aer_pkg::CMD_GO, 16'h0000);
    for (n = 0; n < 5; n++) send_event($random(seed));
    tick;

    if (exp_ipkt.size() != 0 || exp_oaer.size() != 0) begin
      stop_with_failure("expected packets or events were never delivered");
    end else begin
      $display("Finished with no errors");
      $finish;
    end
  end

endmodule

`default_nettype wire

/* spinn_aer_if_top.f */
verilog/spinn_aer_pkg.sv
verilog/pkt_router.sv
verilog/spinn_aer_ctrl.sv
verilog/aer_out_mapper.sv
verilog/aer_in_mapper.sv
verilog/spinn_aer_if_top.sv
bench/spinn_aer_if_chk.sv
bench/tb_spinn_aer_if.sv

/* verilog/aer_in_mapper.sv */
// AER input to SpiNNaker packet mapper
// synchronises the four-phase AER request, captures the address and
// maps it to a multicast packet by mode; while not running the event
// is acknowledged and dropped (dump mode)

`timescale 1ns/1ps
`default_nettype none

module aer_in_mapper (
  input  wire                                 i_clk,
  input  wire                                 i_rst_n,
  input  wire spinn_aer_pkg::mode_t           i_mode,
  input  wire [spinn_aer_pkg::VCRD_BITS-1:0]  i_vcoord,
  input  wire                                 i_go,
  input  wire [spinn_aer_pkg::AER_BITS-1:0]   i_iaer_data,
  input  wire                                 i_iaer_req,
  output logic                                o_iaer_ack,
  output logic [spinn_aer_pkg::PKT_BITS-1:0]  o_ipkt_data,
  output logic                                o_ipkt_vld,
  input  wire                                 i_ipkt_rdy,
  output logic                                o_dump_mode
);

  typedef enum logic [1:0] {IDLE, SEND, ACK, WAIT_REL} state_t;

  state_t                                state;
  logic                                  req_s1;
  logic                                  req_s2;
  logic [spinn_aer_pkg::AER_BITS-1:0]    key_lo;
  logic [spinn_aer_pkg::KEY_BITS-1:0]    key;
  logic [spinn_aer_pkg::PKT_BITS-1:0]    pkt_next;
  logic [spinn_aer_pkg::PKT_BITS-1:0]    pkt_q;
  logic                                  vld_q;
  logic                                  ack_q;

  // --------------------------------------------------------------------------
  // request synchroniser, idles high
  // --------------------------------------------------------------------------
  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      req_s1 <= 1'b1;
      req_s2 <= 1'b1;
    end else begin
      req_s1 <= i_iaer_req;
      req_s2 <= req_s1;
    end
  end

  // --------------------------------------------------------------------------
  // address to key mapping
  // --------------------------------------------------------------------------
  always_comb begin
    case (i_mode)
      // 64x64 retina: zero pad, y, x, polarity
      spinn_aer_pkg::MODE_RETINA_64:
        key_lo = {3'b000, i_iaer_data[14:9], i_iaer_data[6:1], i_iaer_data[7]};
      // direct and unused codes pass the address through
      default:
        key_lo = i_iaer_data;
    endcase
  end

  // coordinate always forms the upper key half
  assign key = {i_vcoord, key_lo};

  // parity bit makes the whole packet odd
  assign pkt_next = {key, spinn_aer_pkg::HDR_MC[7:1],
                     spinn_aer_pkg::HDR_MC[0] ^ ~^{key, spinn_aer_pkg::HDR_MC[7:1]}};

  // --------------------------------------------------------------------------
  // handshake FSM
  // --------------------------------------------------------------------------
  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      state <= IDLE;
      vld_q <= 1'b0;
      ack_q <= 1'b1;
    end else begin
      case (state)
        IDLE: begin
          // synchronised request low, address is stable
          if (!req_s2) begin
            if (i_go) begin
              vld_q <= 1'b1;
              state <= SEND;
            end else begin
              // dump mode, no packet offered
              state <= ACK;
            end
          end
        end
        SEND: begin
          if (i_ipkt_rdy) begin
            vld_q <= 1'b0;
            ack_q <= 1'b0;
            state <= WAIT_REL;
          end
        end
        ACK: begin
          ack_q <= 1'b0;
          state <= WAIT_REL;
        end
        WAIT_REL: begin
          // source released the request
          if (req_s2) begin
            ack_q <= 1'b1;
            state <= IDLE;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  // packet capture
  always_ff @(posedge i_clk) begin
    if (state == IDLE && !req_s2) begin
      pkt_q <= pkt_next;
    end
  end

  assign o_ipkt_data = pkt_q;
  assign o_ipkt_vld  = vld_q;
  assign o_iaer_ack  = ack_q;
  assign o_dump_mode = ~i_go;

endmodule

`default_nettype wire

/* verilog/aer_out_mapper.sv */
// SpiNNaker packet to AER output mapper
// takes the low 16 key bits of each packet as the AER address and
// drives it out over a four-phase handshake with active-low request

`timescale 1ns/1ps
`default_nettype none

module aer_out_mapper (
  input  wire                                 i_clk,
  input  wire                                 i_rst_n,
  input  wire [spinn_aer_pkg::PKT_BITS-1:0]   i_opkt_data,
  input  wire                                 i_opkt_vld,
  output logic                                o_opkt_rdy,
  output logic [spinn_aer_pkg::AER_BITS-1:0]  o_oaer_data,
  output logic                                o_oaer_req,
  input  wire                                 i_oaer_ack
);

  typedef enum logic [1:0] {IDLE, REQ, REL, WAIT_ACK_HI} state_t;

  state_t                              state;
  logic                                ack_s1;
  logic                                ack_s2;
  logic                                req_q;
  logic [spinn_aer_pkg::AER_BITS-1:0]  data_q;

  // --------------------------------------------------------------------------
  // acknowledge synchroniser, idles high
  // --------------------------------------------------------------------------
  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      ack_s1 <= 1'b1;
      ack_s2 <= 1'b1;
    end else begin
      ack_s1 <= i_oaer_ack;
      ack_s2 <= ack_s1;
    end
  end

  // next packet only taken when the previous event is complete
  assign o_opkt_rdy = (state == IDLE);

  // --------------------------------------------------------------------------
  // four-phase sequencer
  // --------------------------------------------------------------------------
  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      state <= IDLE;
      req_q <= 1'b1;
    end else begin
      case (state)
        // address loaded here, request follows a cycle later
        IDLE: if (i_opkt_vld) state <= REQ;
        REQ: begin
          req_q <= 1'b0;
          state <= REL;
        end
        REL: begin
          // device took the address
          if (!ack_s2) begin
            req_q <= 1'b1;
            state <= WAIT_ACK_HI;
          end
        end
        WAIT_ACK_HI: if (ack_s2) state <= IDLE;
        default: state <= IDLE;
      endcase
    end
  end

  // key low half as the AER address
  always_ff @(posedge i_clk) begin
    if (state == IDLE && i_opkt_vld) begin
      data_q <= i_opkt_data[spinn_aer_pkg::KEY_LSB +: spinn_aer_pkg::AER_BITS];
    end
  end

  assign o_oaer_data = data_q;
  assign o_oaer_req  = req_q;

endmodule

`default_nettype wire

/* verilog/pkt_router.sv */
// SpiNNaker packet router
// one-entry register slice for incoming packets; control packets are
// steered to the controller, all others to the AER output mapper

`timescale 1ns/1ps
`default_nettype none

module pkt_router (
  input  wire                                 i_clk,
  input  wire                                 i_rst_n,
  input  wire [spinn_aer_pkg::PKT_BITS-1:0]   i_spkt_data,
  input  wire                                 i_spkt_vld,
  output logic                                o_spkt_rdy,
  output logic [spinn_aer_pkg::PKT_BITS-1:0]  o_cpkt_data,
  output logic                                o_cpkt_vld,
  input  wire                                 i_cpkt_rdy,
  output logic [spinn_aer_pkg::PKT_BITS-1:0]  o_opkt_data,
  output logic                                o_opkt_vld,
  input  wire                                 i_opkt_rdy
);

  logic [spinn_aer_pkg::PKT_BITS-1:0]  data_q;
  logic [15:0]                         key_hi;
  logic                                is_ctrl;
  logic                                full_q;
  logic                                ctrl_q;
  logic                                take;

  // signature check on the key upper half, command nibble ignored
  assign key_hi  = i_spkt_data[spinn_aer_pkg::KEY_LSB + spinn_aer_pkg::KEY_BITS - 1 -: 16];
  assign is_ctrl = ((key_hi | spinn_aer_pkg::CMD_MASK) == spinn_aer_pkg::CTRL_SIG);

  // held packet leaves through its own port
  assign take       = full_q & (ctrl_q ? i_cpkt_rdy : i_opkt_rdy);
  assign o_spkt_rdy = ~full_q | take;

  // --------------------------------------------------------------------------
  // slot state
  // --------------------------------------------------------------------------
  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      full_q <= 1'b0;
      ctrl_q <= 1'b0;
    end else if (i_spkt_vld && o_spkt_rdy) begin
      full_q <= 1'b1;
      ctrl_q <= is_ctrl;
    end else if (take) begin
      full_q <= 1'b0;
    end
  end

  // packet payload
  always_ff @(posedge i_clk) begin
    if (i_spkt_vld && o_spkt_rdy) begin
      data_q <= i_spkt_data;
    end
  end

  assign o_cpkt_data = data_q;
  assign o_cpkt_vld  = full_q & ctrl_q;
  assign o_opkt_data = data_q;
  assign o_opkt_vld  = full_q & ~ctrl_q;

endmodule

`default_nettype wire

/* verilog/spinn_aer_ctrl.sv */
// bridge controller
// decodes control packets into the mapping mode, the virtual
// coordinate and the event forwarding go flag

`timescale 1ns/1ps
`default_nettype none

module spinn_aer_ctrl (
  input  wire                                 i_clk,
  input  wire                                 i_rst_n,
  input  wire [spinn_aer_pkg::PKT_BITS-1:0]   i_cpkt_data,
  input  wire                                 i_cpkt_vld,
  output logic                                o_cpkt_rdy,
  output spinn_aer_pkg::mode_t                o_mode,
  output logic [spinn_aer_pkg::VCRD_BITS-1:0] o_vcoord,
  output logic                                o_go
);

  logic [spinn_aer_pkg::KEY_BITS-1:0]   key;
  spinn_aer_pkg::cmd_t                  cmd;
  logic [spinn_aer_pkg::VCRD_BITS-1:0]  value;

  // field extraction
  assign key   = i_cpkt_data[spinn_aer_pkg::KEY_LSB +: spinn_aer_pkg::KEY_BITS];
  assign cmd   = spinn_aer_pkg::cmd_t'(key[spinn_aer_pkg::CMD_LSB +: 4]);
  assign value = key[spinn_aer_pkg::VCRD_BITS-1:0];

  // control packets never stall
  assign o_cpkt_rdy = 1'b1;

  // --------------------------------------------------------------------------
  // command decode
  // --------------------------------------------------------------------------
  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      o_mode   <= spinn_aer_pkg::MODE_DIRECT;
      o_vcoord <= '0;
      o_go     <= 1'b0;
    end else if (i_cpkt_vld) begin
      case (cmd)
        spinn_aer_pkg::CMD_SET_VCRD: o_vcoord <= value;
        // mode in the low 2 value bits
        spinn_aer_pkg::CMD_SET_MODE: o_mode <= spinn_aer_pkg::mode_t'(value[1:0]);
        spinn_aer_pkg::CMD_GO:       o_go <= 1'b1;
        spinn_aer_pkg::CMD_STOP:     o_go <= 1'b0;
        // unknown code, leave everything
        default: ;
      endcase
    end
  end

endmodule

`default_nettype wire

/* verilog/spinn_aer_if_top.sv */
// SpiNNaker / AER bridge packet core
// router, controller and the two mappers; packets in on valid/ready,
// AER events in and out on four-phase handshakes

`timescale 1ns/1ps
`default_nettype none

module spinn_aer_if_top (
  input  wire                                 i_clk,
  input  wire                                 i_rst_n,
  // packets from SpiNNaker
  input  wire [spinn_aer_pkg::PKT_BITS-1:0]   i_spkt_data,
  input  wire                                 i_spkt_vld,
  output wire                                 o_spkt_rdy,
  // packets to SpiNNaker
  output wire [spinn_aer_pkg::PKT_BITS-1:0]   o_ipkt_data,
  output wire                                 o_ipkt_vld,
  input  wire                                 i_ipkt_rdy,
  // AER input device
  input  wire [spinn_aer_pkg::AER_BITS-1:0]   i_iaer_data,
  input  wire                                 i_iaer_req,
  output wire                                 o_iaer_ack,
  // AER output device
  output wire [spinn_aer_pkg::AER_BITS-1:0]   o_oaer_data,
  output wire                                 o_oaer_req,
  input  wire                                 i_oaer_ack,
  output wire                                 o_dump_mode
);

  // router to controller
  logic [spinn_aer_pkg::PKT_BITS-1:0]   cpkt_data;
  logic                                 cpkt_vld;
  logic                                 cpkt_rdy;

  // router to output mapper
  logic [spinn_aer_pkg::PKT_BITS-1:0]   opkt_data;
  logic                                 opkt_vld;
  logic                                 opkt_rdy;

  // controller settings
  spinn_aer_pkg::mode_t                 ct_mode;
  logic [spinn_aer_pkg::VCRD_BITS-1:0]  ct_vcoord;
  logic                                 ct_go;

  // --------------------------------------------------------------------------
  // packet router
  // --------------------------------------------------------------------------
  pkt_router u_router (
    .i_clk       (i_clk),
    .i_rst_n     (i_rst_n),
    .i_spkt_data (i_spkt_data),
    .i_spkt_vld  (i_spkt_vld),
    .o_spkt_rdy  (o_spkt_rdy),
    .o_cpkt_data (cpkt_data),
    .o_cpkt_vld  (cpkt_vld),
    .i_cpkt_rdy  (cpkt_rdy),
    .o_opkt_data (opkt_data),
    .o_opkt_vld  (opkt_vld),
    .i_opkt_rdy  (opkt_rdy)
  );

  // controller
  spinn_aer_ctrl u_ctrl (
    .i_clk       (i_clk),
    .i_rst_n     (i_rst_n),
    .i_cpkt_data (cpkt_data),
    .i_cpkt_vld  (cpkt_vld),
    .o_cpkt_rdy  (cpkt_rdy),
    .o_mode      (ct_mode),
    .o_vcoord    (ct_vcoord),
    .o_go        (ct_go)
  );

  // --------------------------------------------------------------------------
  // AER mappers
  // --------------------------------------------------------------------------
  aer_out_mapper u_out_map (
    .i_clk       (i_clk),
    .i_rst_n     (i_rst_n),
    .i_opkt_data (opkt_data),
    .i_opkt_vld  (opkt_vld),
    .o_opkt_rdy  (opkt_rdy),
    .o_oaer_data (o_oaer_data),
    .o_oaer_req  (o_oaer_req),
    .i_oaer_ack  (i_oaer_ack)
  );

  // dump mode handled inside
  aer_in_mapper u_in_map (
    .i_clk       (i_clk),
    .i_rst_n     (i_rst_n),
    .i_mode      (ct_mode),
    .i_vcoord    (ct_vcoord),
    .i_go        (ct_go),
    .i_iaer_data (i_iaer_data),
    .i_iaer_req  (i_iaer_req),
    .o_iaer_ack  (o_iaer_ack),
    .o_ipkt_data (o_ipkt_data),
    .o_ipkt_vld  (o_ipkt_vld),
    .i_ipkt_rdy  (i_ipkt_rdy),
    .o_dump_mode (o_dump_mode)
  );

endmodule

`default_nettype wire

/* verilog/spinn_aer_pkg.sv */
// SpiNNaker / AER bridge shared definitions
// packet layout, AER and coordinate widths, control packet signature,
// mapping mode and control command encodings

`default_nettype none

package spinn_aer_pkg;

  // --------------------------------------------------------------------------
  // multicast packet layout
  // --------------------------------------------------------------------------
  // 8-bit header in the low bits, 32-bit routing key above it
  localparam int PKT_BITS  = 40;
  localparam int KEY_LSB   = 8;
  localparam int KEY_BITS  = 32;

  // AER address and virtual coordinate widths
  localparam int AER_BITS  = 16;
  localparam int VCRD_BITS = 16;

  // emitted multicast header, bit 0 replaced by odd parity over the packet
  localparam logic [7:0] HDR_MC = 8'h00;

  // --------------------------------------------------------------------------
  // control packets
  // --------------------------------------------------------------------------
  // key layout {CTRL_SIG[15:4], cmd[3:0], value[15:0]}
  // the command nibble is masked off before the signature compare
  localparam logic [15:0] CTRL_SIG = 16'hFFFF;
  localparam logic [15:0] CMD_MASK = 16'h000F;
  // command field position within the key
  localparam int          CMD_LSB  = 16;

  // mapping modes
  typedef enum logic [1:0] {
    MODE_DIRECT    = 2'd0,
    MODE_RETINA_64 = 2'd1
  } mode_t;

  // control commands, other codes are ignored
  typedef enum logic [3:0] {
    CMD_SET_VCRD = 4'h0,
    CMD_SET_MODE = 4'h1,
    CMD_GO       = 4'h2,
    CMD_STOP     = 4'h3
  } cmd_t;

endpackage

`default_nettype wire
